/* hdl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [7:0]  inst_id_t;

    // rv32 major opcodes seen by predecode
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;

    // one queue slot, 72 bits
    typedef struct packed {
        addr_t    addr;
        inst_t    inst;
        inst_id_t inst_id;
    } fetch_entry_t;

endpackage

`default_nettype wire

/* hdl/branch_counter_table.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_counter_table import fetch_pkg::*; #(
    parameter int bht_index_bits = 6
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire [bht_index_bits+1:2]     lookup_pc,
    input  wire                          br_update_valid,
    input  wire addr_t                   br_update_pc,
    input  wire                          br_update_taken,
    output logic                         pred_taken
);

    localparam int entries = 2 ** bht_index_bits;

    logic [1:0] counters [entries];

    logic [bht_index_bits-1:0] upd_index;
    logic [1:0]                upd_value;
    logic                      upd_saturated;

    assign upd_index = br_update_pc[bht_index_bits+1:2];
    assign upd_value = counters[upd_index];

    // taken at 2 and 3
    assign pred_taken = counters[lookup_pc][1];

    // counter already at the end it is moving toward
    assign upd_saturated = br_update_taken ? (upd_value == 2'd3) : (upd_value == 2'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            // weakly not-taken
            for (int i = 0; i < entries; i++) begin
                counters[i] <= 2'd1;
            end
        end else if (br_update_valid && !upd_saturated) begin
            if (br_update_taken) begin
                counters[upd_index] <= upd_value + 2'd1;
            end else begin
                counters[upd_index] <= upd_value - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/fetch_pc_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_pc_stage import fetch_pkg::*; #(
    parameter addr_t reset_addr  = 32'h0,
    parameter int    queue_depth = 8
) (
    input  wire                         clk,
    input  wire                         reset,

    input  wire                         redirect_valid,
    input  wire addr_t                  redirect_addr,

    output logic                        mem_req_valid,
    output addr_t                       mem_req_addr,
    input  wire                         mem_req_ready,
    input  wire                         mem_resp_valid,

    input  wire                         pred_redirect,
    input  wire addr_t                  pred_target,
    input  wire [$clog2(queue_depth):0] queue_count,

    output addr_t                       resp_pc,
    output logic                        resp_accept
);

    addr_t pc;
    addr_t req_pc;
    addr_t next_pc;
    logic  busy;
    logic  discard;
    logic  req_fire;
    logic  resp_done;

    // a request is only issued while idle, so the in-flight slot is free here
    assign mem_req_valid = !busy && (queue_count < queue_depth);
    assign mem_req_addr  = pc;

    assign req_fire  = mem_req_valid && mem_req_ready;
    assign resp_done = busy && mem_resp_valid;

    assign resp_accept = resp_done && !discard;
    assign resp_pc     = req_pc;

    // back end redirect, then predecode redirect, then fall through
    always_comb begin
        next_pc = pc;
        if (redirect_valid) begin
            next_pc = redirect_addr;
        end else if (resp_accept) begin
            next_pc = pred_redirect ? pred_target : req_pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= reset_addr;
            busy    <= 1'b0;
            discard <= 1'b0;
        end else begin
            pc <= next_pc;

            if (req_fire) begin
                busy <= 1'b1;
            end else if (resp_done) begin
                busy <= 1'b0;
            end

            // anything still outstanding after this edge belongs to the old path
            if (redirect_valid) begin
                discard <= req_fire || (busy && !mem_resp_valid);
            end else if (resp_done) begin
                discard <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_pc <= pc;
        end
    end

    a_resp_only_when_busy: assert property (
        @(posedge clk) disable iff (reset)
        mem_resp_valid |-> busy
    );

    // a stalled request keeps its address until memory takes it
    a_req_addr_stable: assert property (
        @(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready && !redirect_valid
            |=> mem_req_valid && $stable(mem_req_addr)
    );

endmodule

`default_nettype wire

/* hdl/fetch_predecode.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_predecode import fetch_pkg::*; #(
    parameter int bht_index_bits = 6
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      redirect_valid,
    input  wire                      resp_accept,
    input  wire addr_t               resp_pc,
    input  wire inst_t               mem_resp_data,
    input  wire                      pred_taken,

    output logic [bht_index_bits+1:2] lookup_pc,
    output logic                     pred_redirect,
    output addr_t                    pred_target,
    output logic                     entry_wvalid,
    output fetch_entry_t             entry_wdata
);

    logic [6:0] opcode;
    logic       is_jal;
    logic       is_branch;
    addr_t      imm_j;
    addr_t      imm_b;
    inst_id_t   next_id;

    assign opcode    = mem_resp_data[6:0];
    assign is_jal    = (opcode == op_jal);
    assign is_branch = (opcode == op_branch);

    // scattered immediate fields sign extended
    assign imm_j = {{11{mem_resp_data[31]}}, mem_resp_data[31], mem_resp_data[19:12],
                    mem_resp_data[20], mem_resp_data[30:21], 1'b0};
    assign imm_b = {{19{mem_resp_data[31]}}, mem_resp_data[31], mem_resp_data[7],
                    mem_resp_data[30:25], mem_resp_data[11:8], 1'b0};

    assign lookup_pc   = resp_pc[bht_index_bits+1:2];
    assign pred_target = resp_pc + (is_jal ? imm_j : imm_b);

    assign pred_redirect = resp_accept && (is_jal || (is_branch && pred_taken));

    // a word landing on the same edge as a flush never enters the queue
    assign entry_wvalid = resp_accept && !redirect_valid;

    assign entry_wdata.addr    = resp_pc;
    assign entry_wdata.inst    = mem_resp_data;
    assign entry_wdata.inst_id = next_id;

    // ids keep running across redirects
    always_ff @(posedge clk) begin
        if (reset) begin
            next_id <= '0;
        end else if (entry_wvalid) begin
            next_id <= next_id + 8'd1;
        end
    end

    // no compressed instructions, so a taken target is word aligned
    a_redirect_target_aligned: assert property (
        @(posedge clk) disable iff (reset)
        pred_redirect |-> (pred_target[1:0] == 2'b00)
    );

endmodule

`default_nettype wire

/* hdl/sync_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module sync_queue #(
    parameter int data_width = 72,
    parameter int depth      = 8
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     flush,

    input  wire                     wvalid,
    input  wire [data_width-1:0]    wdata,

    input  wire                     rready,
    output logic                    rvalid,
    output logic [data_width-1:0]   rdata,

    output logic [$clog2(depth):0]  count
);

    localparam int ptr_bits = $clog2(depth);

    logic [data_width-1:0] mem [depth];

    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits-1:0] wr_ptr;
    logic                do_read;
    logic                do_write;

    assign rvalid = (count != '0);
    assign rdata  = mem[rd_ptr];

    assign do_read  = rvalid && rready;
    assign do_write = wvalid && !flush;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap on their own for a power of two depth
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // the writer reserves space before it asks, so a full queue never sees a write
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (reset)
        do_write |-> (count < depth)
    );

endmodule

`default_nettype wire

/* hdl/fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit import fetch_pkg::*; #(
    parameter int    queue_depth    = 8,
    parameter addr_t reset_addr     = 32'h0,
    parameter int    bht_index_bits = 6
) (
    input  wire         clk,
    input  wire         reset,

    output logic        mem_req_valid,
    output addr_t       mem_req_addr,
    input  wire         mem_req_ready,
    input  wire         mem_resp_valid,
    input  wire inst_t  mem_resp_data,

    output logic        inst_valid,
    output addr_t       inst_addr,
    output inst_t       inst_data,
    output inst_id_t    inst_id,
    input  wire         inst_ready,

    input  wire         redirect_valid,
    input  wire addr_t  redirect_addr,

    input  wire         br_update_valid,
    input  wire addr_t  br_update_pc,
    input  wire         br_update_taken
);

    addr_t                      resp_pc;
    logic                       resp_accept;
    logic                       pred_redirect;
    addr_t                      pred_target;
    logic [bht_index_bits+1:2]  lookup_pc;
    logic                       pred_taken;
    logic                       entry_wvalid;
    fetch_entry_t               entry_wdata;
    fetch_entry_t               queue_rdata;
    logic [$clog2(queue_depth):0] queue_count;

    fetch_pc_stage #(
        .reset_addr  (reset_addr),
        .queue_depth (queue_depth)
    ) pc_stage_i (
        .clk            (clk),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_addr  (redirect_addr),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .pred_redirect  (pred_redirect),
        .pred_target    (pred_target),
        .queue_count    (queue_count),
        .resp_pc        (resp_pc),
        .resp_accept    (resp_accept)
    );

    fetch_predecode #(
        .bht_index_bits (bht_index_bits)
    ) predecode_i (
        .clk            (clk),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .resp_accept    (resp_accept),
        .resp_pc        (resp_pc),
        .mem_resp_data  (mem_resp_data),
        .pred_taken     (pred_taken),
        .lookup_pc      (lookup_pc),
        .pred_redirect  (pred_redirect),
        .pred_target    (pred_target),
        .entry_wvalid   (entry_wvalid),
        .entry_wdata    (entry_wdata)
    );

    branch_counter_table #(
        .bht_index_bits (bht_index_bits)
    ) counter_table_i (
        .clk             (clk),
        .reset           (reset),
        .lookup_pc       (lookup_pc),
        .br_update_valid (br_update_valid),
        .br_update_pc    (br_update_pc),
        .br_update_taken (br_update_taken),
        .pred_taken      (pred_taken)
    );

    // back end redirect also drops everything already queued
    sync_queue #(
        .data_width ($bits(fetch_entry_t)),
        .depth      (queue_depth)
    ) queue_i (
        .clk    (clk),
        .reset  (reset),
        .flush  (redirect_valid),
        .wvalid (entry_wvalid),
        .wdata  (entry_wdata),
        .rready (inst_ready),
        .rvalid (inst_valid),
        .rdata  (queue_rdata),
        .count  (queue_count)
    );

    assign inst_addr = queue_rdata.addr;
    assign inst_data = queue_rdata.inst;
    assign inst_id   = queue_rdata.inst_id;

endmodule

`default_nettype wire

/* verif/fetch_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_clock_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* verif/fetch_unit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit_tb import fetch_pkg::*; ();

    localparam int    queue_depth    = 8;
    localparam addr_t reset_addr     = 32'h0;
    localparam int    bht_index_bits = 6;
    localparam int    max_exp        = 64;
    localparam int    max_ev         = 16;

    logic     clk;
    logic     reset;
    logic     mem_req_valid;
    addr_t    mem_req_addr;
    logic     mem_req_ready;
    logic     mem_resp_valid;
    inst_t    mem_resp_data;
    logic     inst_valid;
    addr_t    inst_addr;
    inst_t    inst_data;
    inst_id_t inst_id;
    logic     inst_ready;
    logic     redirect_valid;
    addr_t    redirect_addr;
    logic     br_update_valid;
    addr_t    br_update_pc;
    logic     br_update_taken;

    inst_t    image [256];
    addr_t    exp_addr [max_exp];
    inst_t    exp_word [max_exp];
    logic     ev_is_redirect [max_ev];
    int       ev_at [max_ev];
    addr_t    ev_addr [max_ev];
    logic     ev_taken [max_ev];
    int       n_exp;
    int       n_ev;
    int       ev_idx;
    int       errors;
    int       consumed;
    int       cycles;
    int       limit;
    logic     timed_out;
    logic [31:0] rng;
    logic     resp_pending;
    int       resp_delay;
    addr_t    resp_addr;
    int       stall_left;
    inst_id_t last_id;
    logic     after_redirect;

    fetch_clock_gen #(
        .period_ns    (20),
        .reset_cycles (3)
    ) clock_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    fetch_unit #(
        .queue_depth    (queue_depth),
        .reset_addr     (reset_addr),
        .bht_index_bits (bht_index_bits)
    ) fetch_unit_i (
        .clk             (clk),
        .reset           (reset),
        .mem_req_valid   (mem_req_valid),
        .mem_req_addr    (mem_req_addr),
        .mem_req_ready   (mem_req_ready),
        .mem_resp_valid  (mem_resp_valid),
        .mem_resp_data   (mem_resp_data),
        .inst_valid      (inst_valid),
        .inst_addr       (inst_addr),
        .inst_data       (inst_data),
        .inst_id         (inst_id),
        .inst_ready      (inst_ready),
        .redirect_valid  (redirect_valid),
        .redirect_addr   (redirect_addr),
        .br_update_valid (br_update_valid),
        .br_update_pc    (br_update_pc),
        .br_update_taken (br_update_taken)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic load_vectors();
        int            fd;
        int            code;
        int            open_from;
        logic [63:0]   tag;
        logic [1023:0] rest;
        logic [31:0]   a;
        logic [31:0]   b;
        open_from = 0;
        fd = $fopen("verif/fetch_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vectors file verif/fetch_vectors.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%h %h", a, b);
                if (tag == "M") begin
                    image[a[9:2]] = b;
                end else if (tag == "E") begin
                    exp_addr[n_exp] = a;
                    exp_word[n_exp] = b;
                    n_exp++;
                end else if (tag == "U" || tag == "R") begin
                    ev_is_redirect[n_ev] = (tag == "R");
                    ev_addr[n_ev]        = (tag == "R") ? b : a;
                    ev_taken[n_ev]       = b[0];
                    n_ev++;
                    // updates wait for the redirect that follows them
                    if (tag == "R") begin
                        for (int k = open_from; k < n_ev; k++) begin
                            ev_at[k] = a;
                        end
                        open_from = n_ev;
                    end
                end else begin
                    $display("unknown record type %0s in the vectors file", tag);
                    errors++;
                end
            end
        end
        $fclose(fd);
    endtask

    // first cycle out of reset requests reset_addr with an empty queue
    task automatic check_reset_state();
        if (mem_req_valid !== 1'b1) begin
            $display("ERROR mem_req_valid: got %h expected %h after reset",
                     mem_req_valid, 1'b1);
            errors++;
        end
        if (mem_req_addr !== reset_addr) begin
            $display("ERROR mem_req_addr: got %h expected %h after reset",
                     mem_req_addr, reset_addr);
            errors++;
        end
        if (inst_valid !== 1'b0) begin
            $display("ERROR inst_valid: got %h expected %h after reset",
                     inst_valid, 1'b0);
            errors++;
        end
    endtask

    // memory answers 1 to 3 cycles after it takes a request
    task automatic drive_memory();
        mem_resp_valid = 1'b0;
        if (resp_pending) begin
            if (resp_delay == 1) begin
                mem_resp_valid = 1'b1;
                mem_resp_data  = image[resp_addr[9:2]];
                resp_pending   = 1'b0;
            end else begin
                resp_delay--;
            end
        end
        if (mem_req_valid && resp_pending) begin
            $display("a second memory request was raised while one is still outstanding");
            errors++;
        end
        rng = lcg_next(rng);
        mem_req_ready = (rng[17:16] != 2'b00);
        if (mem_req_valid && mem_req_ready) begin
            resp_pending = 1'b1;
            resp_addr    = mem_req_addr;
            resp_delay   = 1 + int'(rng[25:24]) % 3;
        end
    endtask

    task automatic check_entry(input int n);
        inst_id_t gap;
        gap = inst_id - last_id;
        if (inst_addr !== exp_addr[n]) begin
            $display("ERROR inst_addr: got %h expected %h (entry %0d)", inst_addr, exp_addr[n], n);
            errors++;
        end
        if (inst_data !== exp_word[n]) begin
            $display("ERROR inst_data: got %h expected %h (entry %0d)", inst_data, exp_word[n], n);
            errors++;
        end
        if (n == 0) begin
            if (inst_id !== 8'h00) begin
                $display("ERROR inst_id: got %h expected %h", inst_id, 8'h00);
                errors++;
            end
        end else if (!after_redirect) begin
            if (gap !== 8'd1) begin
                $display("ERROR inst_id: got %h expected %h", inst_id, last_id + 8'd1);
                errors++;
            end
        end else if (gap == 8'd0 || gap > queue_depth + 1) begin
            // flushed entries used up at most a queue's worth of ids
            $display("ERROR inst_id: got %h after %h across a redirect", inst_id, last_id);
            errors++;
        end
        last_id        = inst_id;
        after_redirect = 1'b0;
    endtask

    task automatic drive_decode(input logic hold);
        rng = lcg_next(rng);
        if (stall_left > 0) begin
            stall_left--;
        end else if (rng[21:18] == 4'h0) begin
            // long enough for fetch to fill the queue
            stall_left = 3 * queue_depth + int'(rng[30:27]);
        end
        inst_ready = !hold && (stall_left == 0) && (rng[31:30] != 2'b00) && (consumed < n_exp);
        if (inst_ready && inst_valid) begin
            check_entry(consumed);
            consumed++;
        end
    endtask

    initial begin
        logic hold;
        mem_req_ready   = 1'b0;
        mem_resp_valid  = 1'b0;
        mem_resp_data   = '0;
        inst_ready      = 1'b0;
        redirect_valid  = 1'b0;
        redirect_addr   = '0;
        br_update_valid = 1'b0;
        br_update_pc    = '0;
        br_update_taken = 1'b0;
        rng             = 32'd41187;
        n_exp           = 0;
        n_ev            = 0;
        ev_idx          = 0;
        errors          = 0;
        consumed        = 0;
        cycles          = 0;
        timed_out       = 1'b0;
        resp_pending    = 1'b0;
        resp_delay      = 0;
        resp_addr       = '0;
        stall_left      = 0;
        last_id         = '0;
        after_redirect  = 1'b0;
        // addi pattern off the program and never a jump or branch
        for (int i = 0; i < 256; i++) begin
            image[i] = {i[7:0], 8'ha5, i[7:0], 8'h13};
        end
        load_vectors();
        if (n_exp == 0) begin
            $display("the vectors file holds no expected instructions");
            errors++;
        end
        limit = 40 * n_exp + 200;

        wait (reset === 1'b1);
        wait (reset === 1'b0);
        while (consumed < n_exp && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                timed_out = 1'b1;
            end else begin
                if (cycles == 1) begin
                    check_reset_state();
                end
                drive_memory();
                redirect_valid  = 1'b0;
                br_update_valid = 1'b0;
                // decode stops taking entries while back end events are pending
                hold = (ev_idx < n_ev) && (consumed == ev_at[ev_idx]);
                if (hold) begin
                    if (ev_is_redirect[ev_idx]) begin
                        redirect_valid = 1'b1;
                        redirect_addr  = ev_addr[ev_idx];
                        after_redirect = 1'b1;
                    end else begin
                        br_update_valid = 1'b1;
                        br_update_pc    = ev_addr[ev_idx];
                        br_update_taken = ev_taken[ev_idx];
                    end
                    ev_idx++;
                end
                drive_decode(hold);
            end
        end

        if (timed_out) begin
            $display("timeout after %0d cycles, only %0d of %0d instructions came out",
                     limit, consumed, n_exp);
        end
        $display("errors: %0d  checked: %0d of %0d", errors, consumed, n_exp);
        if (errors == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/fetch_vectors.txt */
# M addr word: program image, E addr word: expected output in order (all fields hex)
# U pc taken: counter update, R count addr: redirect after count outputs
# U records are applied just before the R that follows them
M 00000000 00108093
M 00000004 00210113
M 00000008 0180006f
M 00000020 00420213
M 00000024 00208e63
M 00000028 00528293
M 0000002c fd5ff06f
M 00000040 00630313
M 00000044 fbdff06f
M 00000100 00738393
M 00000104 00840413
M 00000108 ff9ff06f
# straight line, jal forward, untrained branch falls through, jal backward
E 00000000 00108093
E 00000004 00210113
E 00000008 0180006f
E 00000020 00420213
E 00000024 00208e63
E 00000028 00528293
E 0000002c fd5ff06f
E 00000000 00108093
E 00000004 00210113
R 00000009 00000100
E 00000100 00738393
E 00000104 00840413
E 00000108 ff9ff06f
E 00000100 00738393
E 00000104 00840413
# branch at 0x24 trained toward taken
U 00000024 1
U 00000024 1
R 0000000e 00000000
E 00000000 00108093
E 00000004 00210113
E 00000008 0180006f
E 00000020 00420213
E 00000024 00208e63
E 00000040 00630313
E 00000044 fbdff06f
E 00000000 00108093
# trained back to not taken
U 00000024 0
U 00000024 0
R 00000016 00000000
E 00000000 00108093
E 00000004 00210113
E 00000008 0180006f
E 00000020 00420213
E 00000024 00208e63
E 00000028 00528293

/* project.f */
hdl/fetch_pkg.sv
hdl/branch_counter_table.sv
hdl/fetch_pc_stage.sv
hdl/fetch_predecode.sv
hdl/sync_queue.sv
hdl/fetch_unit.sv
verif/fetch_clock_gen.sv
verif/fetch_unit_tb.sv

/* Makefile */
VERILATOR  := verilator
TOP        := fetch_unit_tb
RTL_TOP    := fetch_unit
FILELIST   := project.f
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then exit 1; fi
	@grep -qF "*** TEST PASSED ***" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
